// File: verilog/alu_data_pkg.sv
/* alu data package
   operand and result width, flag vector type and flag bit positions */
`default_nettype none

package alu_data_pkg;

  localparam int WORD_WIDTH = 64;
  localparam int FLAG_WIDTH = 6;

  // operand or result
  typedef logic [WORD_WIDTH-1:0] word_t;

  // C, O, A, S, Z, P from msb down
  typedef logic [FLAG_WIDTH-1:0] flags_t;

  localparam int FLAG_C = 5; // carry, set when no borrow
  localparam int FLAG_O = 4; // signed overflow
  localparam int FLAG_A = 3; // half carry out of bit 3
  localparam int FLAG_S = 2;
  localparam int FLAG_Z = 1;
  localparam int FLAG_P = 0; // even parity of low byte

endpackage

`default_nettype wire

// File: verilog/alu_op_pkg.sv
/* alu operation package
   opcode, condition code and decode class encodings */
`default_nettype none

package alu_op_pkg;

  typedef logic [7:0] alu_op_t;

  // arithmetic
  localparam alu_op_t OP_ADD64 = 8'h00;
  localparam alu_op_t OP_ADD32 = 8'h01;
  localparam alu_op_t OP_SUB64 = 8'h02;
  localparam alu_op_t OP_SUB32 = 8'h03;

  // logic
  localparam alu_op_t OP_AND64 = 8'h04;
  localparam alu_op_t OP_AND32 = 8'h05;
  localparam alu_op_t OP_OR64 = 8'h06;
  localparam alu_op_t OP_OR32 = 8'h07;
  localparam alu_op_t OP_XOR64 = 8'h08;
  localparam alu_op_t OP_XOR32 = 8'h09;
  localparam alu_op_t OP_XNOR64 = 8'h0a;
  localparam alu_op_t OP_XNOR32 = 8'h0b;

  // moves and extensions of b
  localparam alu_op_t OP_MOV64 = 8'h10;
  localparam alu_op_t OP_MOV32 = 8'h11;
  localparam alu_op_t OP_ZXT8 = 8'h12;
  localparam alu_op_t OP_ZXT16 = 8'h13;
  localparam alu_op_t OP_SXT8 = 8'h14;
  localparam alu_op_t OP_SXT16 = 8'h15;
  localparam alu_op_t OP_SXT32 = 8'h16;

  localparam alu_op_t OP_CMOV = 8'h18;
  localparam alu_op_t OP_CSET = 8'h19;

  typedef logic [3:0] cond_t;

  localparam cond_t COND_Z = 4'd0;
  localparam cond_t COND_NZ = 4'd1;
  localparam cond_t COND_S = 4'd2;
  localparam cond_t COND_NS = 4'd3;
  localparam cond_t COND_UGT = 4'd4;
  localparam cond_t COND_ULE = 4'd5;
  localparam cond_t COND_UGE = 4'd6;
  localparam cond_t COND_ULT = 4'd7;
  localparam cond_t COND_SGT = 4'd8;
  localparam cond_t COND_SLE = 4'd9;
  localparam cond_t COND_SGE = 4'd10;
  localparam cond_t COND_SLT = 4'd11;
  localparam cond_t COND_O = 4'd12;
  localparam cond_t COND_NO = 4'd13;
  localparam cond_t COND_P = 4'd14;
  localparam cond_t COND_ALWAYS = 4'd15;

  typedef logic [1:0] res_class_t;

  localparam res_class_t RES_ARITH = 2'd0;
  localparam res_class_t RES_LOGIC_MOVE = 2'd1;
  localparam res_class_t RES_NONE = 2'd2; // result forced to 0

  typedef logic [1:0] flag_class_t;

  localparam flag_class_t FLG_ARITH = 2'd0;
  localparam flag_class_t FLG_LOGIC = 2'd1;
  localparam flag_class_t FLG_KEEP = 2'd2;

endpackage

`default_nettype wire

// File: verilog/alu_decode.sv
/* alu opcode decoder
   result class, flag class, subtract and 32-bit form per opcode */
`timescale 1ns/1ns
`default_nettype none

module alu_decode (
  input  alu_op_pkg::alu_op_t     op,
  output alu_op_pkg::res_class_t  res_class,
  output alu_op_pkg::flag_class_t flag_class,
  output logic                    is_sub,
  output logic                    is_narrow
);

  import alu_op_pkg::*;

  always_comb
  begin
    res_class = RES_NONE;
    flag_class = FLG_KEEP; // undefined ops leave flags alone
    is_sub = 1'b0;
    is_narrow = 1'b0;
    case (op)
      OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32:
      begin
        res_class = RES_ARITH;
        flag_class = FLG_ARITH;
        is_sub = (op == OP_SUB64) || (op == OP_SUB32);
        is_narrow = (op == OP_ADD32) || (op == OP_SUB32);
      end
      OP_AND64, OP_OR64, OP_XOR64, OP_XNOR64:
      begin
        res_class = RES_LOGIC_MOVE;
        flag_class = FLG_LOGIC;
      end
      OP_AND32, OP_OR32, OP_XOR32, OP_XNOR32:
      begin
        res_class = RES_LOGIC_MOVE;
        flag_class = FLG_LOGIC;
        is_narrow = 1'b1;
      end
      OP_MOV32:
      begin
        res_class = RES_LOGIC_MOVE;
        is_narrow = 1'b1;
      end
      OP_MOV64, OP_ZXT8, OP_ZXT16, OP_SXT8, OP_SXT16, OP_SXT32,
      OP_CMOV, OP_CSET:
        res_class = RES_LOGIC_MOVE; // flags kept
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/alu_adder.sv
/* alu adder
   add or subtract with carry, overflow and half carry at 64 or 32 bits */
`timescale 1ns/1ns
`default_nettype none

module alu_adder (
  input  alu_data_pkg::word_t a,
  input  alu_data_pkg::word_t b,
  input  logic                is_sub,
  input  logic                is_narrow,
  output alu_data_pkg::word_t sum,
  output logic                arith_c,
  output logic                arith_o,
  output logic                arith_a
);

  import alu_data_pkg::*;

  word_t b_eff;
  logic [WORD_WIDTH:0] full;
  logic carry32;
  logic carry4;
  logic sign_a;
  logic sign_b;
  logic sign_r;

  // subtract as a + ~b + 1
  assign b_eff = is_sub ? ~b : b;
  assign full = {1'b0, a} + {1'b0, b_eff} + {{WORD_WIDTH{1'b0}}, is_sub};

  // carry into a bit is its sum bit xor both operand bits
  assign carry32 = full[32] ^ a[32] ^ b_eff[32];
  assign carry4 = full[4] ^ a[4] ^ b_eff[4];

  assign sum = is_narrow ? {32'b0, full[31:0]} : full[WORD_WIDTH-1:0];

  assign sign_a = is_narrow ? a[31] : a[WORD_WIDTH-1];
  assign sign_b = is_narrow ? b_eff[31] : b_eff[WORD_WIDTH-1];
  assign sign_r = is_narrow ? full[31] : full[WORD_WIDTH-1];

  assign arith_c = is_narrow ? carry32 : full[WORD_WIDTH];
  assign arith_o = (sign_a ~^ sign_b) & (sign_r ^ sign_a); // same signs in, other sign out
  assign arith_a = carry4 ^ is_sub;

endmodule

`default_nettype wire

// File: verilog/alu_cond_eval.sv
/* condition comparator
   tests a condition code against the incoming flags */
`timescale 1ns/1ns
`default_nettype none

module alu_cond_eval (
  input  alu_data_pkg::flags_t flags,
  input  alu_op_pkg::cond_t    cond,
  output logic                 cond_true
);

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  logic c;
  logic o;
  logic s;
  logic z;
  logic p;
  logic lt; // signed less than

  assign c = flags[FLAG_C];
  assign o = flags[FLAG_O];
  assign s = flags[FLAG_S];
  assign z = flags[FLAG_Z];
  assign p = flags[FLAG_P];
  assign lt = s ^ o;

  always_comb
  begin
    cond_true = 1'b0;
    case (cond)
      COND_Z:      cond_true = z;
      COND_NZ:     cond_true = ~z;
      COND_S:      cond_true = s;
      COND_NS:     cond_true = ~s;
      COND_UGT:    cond_true = c & ~z;
      COND_ULE:    cond_true = ~c | z;
      COND_UGE:    cond_true = c;
      COND_ULT:    cond_true = ~c;
      COND_SGT:    cond_true = ~(lt | z);
      COND_SLE:    cond_true = lt | z;
      COND_SGE:    cond_true = ~lt;
      COND_SLT:    cond_true = lt;
      COND_O:      cond_true = o;
      COND_NO:     cond_true = ~o;
      COND_P:      cond_true = p;
      COND_ALWAYS: cond_true = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/alu_logic_move.sv
/* logic and move unit
   bitwise ops, moves, extensions, conditional move and set */
`timescale 1ns/1ns
`default_nettype none

module alu_logic_move (
  input  alu_op_pkg::alu_op_t op,
  input  alu_data_pkg::word_t a,
  input  alu_data_pkg::word_t b,
  input  logic                is_narrow,
  input  logic                cond_true,
  output alu_data_pkg::word_t lm_result
);

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  word_t full;

  always_comb
  begin
    full = '0;
    case (op)
      OP_AND64, OP_AND32:
        full = a & b;
      OP_OR64, OP_OR32:
        full = a | b;
      OP_XOR64, OP_XOR32:
        full = a ^ b;
      OP_XNOR64, OP_XNOR32:
        full = ~(a ^ b);
      OP_MOV64, OP_MOV32:
        full = b;
      OP_ZXT8:
        full = {56'b0, b[7:0]};
      OP_ZXT16:
        full = {48'b0, b[15:0]};
      OP_SXT8:
        full = {{56{b[7]}}, b[7:0]};
      OP_SXT16:
        full = {{48{b[15]}}, b[15:0]};
      OP_SXT32:
        full = {{32{b[31]}}, b[31:0]};
      OP_CMOV:
        full = cond_true ? b : a; // b on condition met
      OP_CSET:
        full = {{(WORD_WIDTH-1){1'b0}}, cond_true};
      default: ;
    endcase
  end

  // 32-bit forms clear the upper half
  assign lm_result = is_narrow ? {32'b0, full[31:0]} : full;

endmodule

`default_nettype wire

// File: verilog/alu_retire.sv
/* alu return stage
   registers the selected result and builds the returned flags */
`timescale 1ns/1ns
`default_nettype none

module alu_retire (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    op_valid,
  input  logic                    set_flags,
  input  alu_op_pkg::res_class_t  res_class,
  input  alu_op_pkg::flag_class_t flag_class,
  input  logic                    is_narrow,
  input  alu_data_pkg::word_t     sum,
  input  alu_data_pkg::word_t     lm_result,
  input  logic                    arith_c,
  input  logic                    arith_o,
  input  logic                    arith_a,
  input  alu_data_pkg::flags_t    flags_in,
  output logic                    ret_valid,
  output alu_data_pkg::word_t     result,
  output alu_data_pkg::flags_t    flags_out,
  output logic                    flags_we
);

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  word_t result_d;
  logic c_q;
  logic o_q;
  logic a_q;
  logic narrow_q;
  logic set_flags_q;
  flag_class_t flag_class_q;
  flags_t flags_in_q;
  logic s_bit;
  logic z_bit;
  logic p_bit;

  always_comb
  begin
    case (res_class)
      RES_ARITH:      result_d = sum;
      RES_LOGIC_MOVE: result_d = lm_result;
      default:        result_d = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ret_valid <= 1'b0;
      result <= '0;
      c_q <= 1'b0;
      o_q <= 1'b0;
      a_q <= 1'b0;
      narrow_q <= 1'b0;
      set_flags_q <= 1'b0;
      flag_class_q <= FLG_KEEP;
      flags_in_q <= '0;
    end
    else
    begin
      ret_valid <= op_valid;
      if (op_valid) // idle cycles hold the last return
      begin
        result <= result_d;
        c_q <= arith_c;
        o_q <= arith_o;
        a_q <= arith_a;
        narrow_q <= is_narrow;
        set_flags_q <= set_flags;
        flag_class_q <= flag_class;
        flags_in_q <= flags_in;
      end
    end
  end

  assign s_bit = narrow_q ? result[31] : result[WORD_WIDTH-1];
  assign z_bit = narrow_q ? (result[31:0] == 32'b0) : (result == '0);
  assign p_bit = ~^result[7:0]; // even parity

  always_comb
  begin
    flags_out = flags_in_q;
    if (set_flags_q && (flag_class_q == FLG_ARITH || flag_class_q == FLG_LOGIC))
    begin
      flags_out[FLAG_C] = (flag_class_q == FLG_ARITH) & c_q;
      flags_out[FLAG_O] = (flag_class_q == FLG_ARITH) & o_q;
      flags_out[FLAG_A] = (flag_class_q == FLG_ARITH) & a_q;
      flags_out[FLAG_S] = s_bit;
      flags_out[FLAG_Z] = z_bit;
      flags_out[FLAG_P] = p_bit;
    end
  end

  assign flags_we = ret_valid & set_flags_q & (flag_class_q != FLG_KEEP);

endmodule

`default_nettype wire

// File: verilog/alu.sv
/* single-cycle integer alu stage
   one operation in per cycle, registered result and flags one cycle later */
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 op_valid,
  input  alu_op_pkg::alu_op_t  op,
  input  alu_op_pkg::cond_t    cond,
  input  logic                 set_flags,
  input  alu_data_pkg::flags_t flags_in,
  input  alu_data_pkg::word_t  a,
  input  alu_data_pkg::word_t  b,
  output logic                 ret_valid,
  output alu_data_pkg::word_t  result,
  output alu_data_pkg::flags_t flags_out,
  output logic                 flags_we
);

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  res_class_t res_class;
  flag_class_t flag_class;
  logic is_sub;
  logic is_narrow;
  word_t sum;
  logic arith_c;
  logic arith_o;
  logic arith_a;
  logic cond_true;
  word_t lm_result;

  alu_decode decode_inst (
    .op         (op),
    .res_class  (res_class),
    .flag_class (flag_class),
    .is_sub     (is_sub),
    .is_narrow  (is_narrow)
  );

  alu_adder adder_inst (
    .a         (a),
    .b         (b),
    .is_sub    (is_sub),
    .is_narrow (is_narrow),
    .sum       (sum),
    .arith_c   (arith_c),
    .arith_o   (arith_o),
    .arith_a   (arith_a)
  );

  // condition taken from the incoming flags, not the returned ones
  alu_cond_eval cond_eval_inst (
    .flags     (flags_in),
    .cond      (cond),
    .cond_true (cond_true)
  );

  alu_logic_move logic_move_inst (
    .op        (op),
    .a         (a),
    .b         (b),
    .is_narrow (is_narrow),
    .cond_true (cond_true),
    .lm_result (lm_result)
  );

  alu_retire retire_inst (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .set_flags  (set_flags),
    .res_class  (res_class),
    .flag_class (flag_class),
    .is_narrow  (is_narrow),
    .sum        (sum),
    .lm_result  (lm_result),
    .arith_c    (arith_c),
    .arith_o    (arith_o),
    .arith_a    (arith_a),
    .flags_in   (flags_in),
    .ret_valid  (ret_valid),
    .result     (result),
    .flags_out  (flags_out),
    .flags_we   (flags_we)
  );

endmodule

`default_nettype wire

// File: verif/alu_asserts.sv
/* alu return interface assertions
   valid timing after reset and against the issued ops */
`timescale 1ns/1ns
`default_nettype none

module alu_asserts (
  input logic clk,
  input logic rst,
  input logic op_valid,
  input logic ret_valid,
  input logic flags_we
);

  valid_low_after_reset: assert property (@(posedge clk) rst |=> !ret_valid)
    else $error("ret_valid high in the cycle after reset");

  we_needs_valid: assert property (@(posedge clk) flags_we |-> ret_valid)
    else $error("flags_we high without ret_valid");

  // one cycle from op to return
  valid_follows_op: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> (ret_valid == $past(op_valid)))
    else $error("ret_valid does not follow op_valid by one cycle");

endmodule

`default_nettype wire

// File: verif/alu_tb.sv
/* alu testbench
   directed tests of the alu stage against a reference model */
`timescale 1ns/1ns
`default_nettype none

module alu_tb;

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  localparam int ARITH_RANDOM = 10;
  localparam int LM_RANDOM = 4;
  localparam int STREAM_OPS = 32;
  // one cycle per operation plus reset and idle cycles
  localparam int TEST_CYCLES = 16 + 4 * (3 + ARITH_RANDOM) + 15 * LM_RANDOM + 16 * 64 * 2
                               + STREAM_OPS;
  localparam int MAX_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

  logic clk;
  logic rst;
  logic op_valid;
  alu_op_t op;
  cond_t cond;
  logic set_flags;
  flags_t flags_in;
  word_t a;
  word_t b;
  logic ret_valid;
  word_t result;
  flags_t flags_out;
  logic flags_we;

  string test_name;
  int cycle_count = 0;
  word_t rng_state;
  logic pend; // one return expected at the next falling edge
  logic pend_narrow;
  word_t pend_res;
  flags_t pend_flags;
  logic pend_we;
  word_t last_res;

  alu alu_inst (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .op        (op),
    .cond      (cond),
    .set_flags (set_flags),
    .flags_in  (flags_in),
    .a         (a),
    .b         (b),
    .ret_valid (ret_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

  bind alu alu_asserts asserts_inst (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .ret_valid (ret_valid),
    .flags_we  (flags_we)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("timeout: tests still running after %0d cycles", cycle_count);
      $display("Simulation failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic word_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  function automatic flags_t random_flags();
    word_t r;
    r = next_random();
    return r[FLAG_WIDTH-1:0];
  endfunction

  function automatic logic cond_holds(input cond_t cc, input flags_t f);
    logic ugt;
    logic slt;
    logic sle;
    ugt = f[FLAG_C] & ~f[FLAG_Z];
    slt = f[FLAG_S] ^ f[FLAG_O];
    sle = slt | f[FLAG_Z];
    case (cc)
      COND_Z:   return f[FLAG_Z];
      COND_NZ:  return ~f[FLAG_Z];
      COND_S:   return f[FLAG_S];
      COND_NS:  return ~f[FLAG_S];
      COND_UGT: return ugt;
      COND_ULE: return ~ugt;
      COND_UGE: return f[FLAG_C];
      COND_ULT: return ~f[FLAG_C];
      COND_SGT: return ~sle;
      COND_SLE: return sle;
      COND_SGE: return ~slt;
      COND_SLT: return slt;
      COND_O:   return f[FLAG_O];
      COND_NO:  return ~f[FLAG_O];
      COND_P:   return f[FLAG_P];
      default:  return 1'b1; // always
    endcase
  endfunction

  // reference model of one operation
  function automatic void model_op(input alu_op_t o, input cond_t cc, input logic sf,
                                   input flags_t fin, input word_t x, input word_t y,
                                   output word_t res, output flags_t flg, output logic we);
    logic sub;
    logic narrow;
    logic arith;
    logic logical;
    logic taken;
    word_t yx;
    logic [64:0] wide;
    logic [32:0] half;
    logic [4:0] nib;
    logic sa;
    logic sb;
    logic sr;
    sub = (o == OP_SUB64) || (o == OP_SUB32);
    narrow = o inside {OP_ADD32, OP_SUB32, OP_AND32, OP_OR32, OP_XOR32, OP_XNOR32, OP_MOV32};
    arith = o inside {OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32};
    logical = o inside {OP_AND64, OP_AND32, OP_OR64, OP_OR32,
                        OP_XOR64, OP_XOR32, OP_XNOR64, OP_XNOR32};
    taken = cond_holds(cc, fin);
    yx = sub ? ~y : y; // a + ~b + 1
    wide = {1'b0, x} + {1'b0, yx} + 65'(sub);
    half = {1'b0, x[31:0]} + {1'b0, yx[31:0]} + 33'(sub);
    nib = {1'b0, x[3:0]} + {1'b0, yx[3:0]} + 5'(sub);
    case (o)
      OP_ADD64, OP_SUB64, OP_ADD32, OP_SUB32: res = wide[63:0];
      OP_AND64, OP_AND32:   res = x & y;
      OP_OR64, OP_OR32:     res = x | y;
      OP_XOR64, OP_XOR32:   res = x ^ y;
      OP_XNOR64, OP_XNOR32: res = ~(x ^ y);
      OP_MOV64, OP_MOV32:   res = y;
      OP_ZXT8:  res = {56'h0, y[7:0]};
      OP_ZXT16: res = {48'h0, y[15:0]};
      OP_SXT8:  res = {{56{y[7]}}, y[7:0]};
      OP_SXT16: res = {{48{y[15]}}, y[15:0]};
      OP_SXT32: res = {{32{y[31]}}, y[31:0]};
      OP_CMOV:  res = taken ? y : x;
      OP_CSET:  res = {63'h0, taken};
      default:  res = '0;
    endcase
    if (narrow)
      res[63:32] = 32'h0;
    sa = narrow ? x[31] : x[63];
    sb = narrow ? yx[31] : yx[63];
    sr = narrow ? res[31] : res[63];
    flg = fin;
    we = sf && (arith || logical);
    if (we)
    begin
      flg[FLAG_C] = arith & (narrow ? half[32] : wide[64]);
      flg[FLAG_O] = arith & (sa == sb) & (sr != sa);
      flg[FLAG_A] = arith & (nib[4] ^ sub);
      flg[FLAG_S] = sr;
      flg[FLAG_Z] = narrow ? (res[31:0] == 32'h0) : (res == '0);
      flg[FLAG_P] = ~^res[7:0];
    end
  endfunction

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_flags(input string what, input flags_t expected, input flags_t actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // return of last cycle's op, or an idle return holding the result
  task automatic check_return();
    if (pend)
    begin
      check_bit("ret_valid", 1'b1, ret_valid);
      if (pend_narrow)
        check_word("upper half", '0, {32'h0, result[63:32]});
      check_word("result", pend_res, result);
      check_flags("flags_out", pend_flags, flags_out);
      check_bit("flags_we", pend_we, flags_we);
      last_res = pend_res;
      pend = 1'b0;
    end
    else
    begin
      check_bit("idle ret_valid", 1'b0, ret_valid);
      check_bit("idle flags_we", 1'b0, flags_we);
      check_word("held result", last_res, result);
    end
  endtask

  task automatic issue(input alu_op_t o, input cond_t cc, input logic sf, input flags_t f,
                       input word_t x, input word_t y);
    @(negedge clk);
    check_return();
    model_op(o, cc, sf, f, x, y, pend_res, pend_flags, pend_we);
    pend = 1'b1;
    pend_narrow = o inside {OP_ADD32, OP_SUB32, OP_AND32, OP_OR32, OP_XOR32, OP_XNOR32, OP_MOV32};
    op_valid = 1'b1;
    op = o;
    cond = cc;
    set_flags = sf;
    flags_in = f;
    a = x;
    b = y;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    check_return();
    op_valid = 1'b0;
  endtask

  task automatic test_reset();
    test_name = "test_reset";
    check_bit("ret_valid", 1'b0, ret_valid);
    check_bit("flags_we", 1'b0, flags_we);
    check_word("result", '0, result);
    check_flags("flags_out", '0, flags_out);
    idle_cycle();
  endtask

  task automatic test_arith();
    alu_op_t ops[4];
    int i;
    int k;
    test_name = "test_arith";
    ops = '{OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32};
    for (k = 0; k < 4; k++)
    begin
      issue(ops[k], COND_ALWAYS, 1'b1, random_flags(), '1, 64'h1); // wraps to zero
      issue(ops[k], COND_ALWAYS, 1'b1, random_flags(), 64'h8000_0000_0000_0000, 64'h1);
      issue(ops[k], COND_ALWAYS, 1'b1, random_flags(), 64'h0000_0000_8000_0000, 64'h1);
      for (i = 0; i < ARITH_RANDOM; i++)
        issue(ops[k], COND_ALWAYS, 1'b1, random_flags(), next_random(), next_random());
    end
    idle_cycle();
  endtask

  task automatic test_logic_move();
    alu_op_t ops[15];
    int i;
    int k;
    test_name = "test_logic_move";
    ops = '{OP_AND64, OP_AND32, OP_OR64, OP_OR32, OP_XOR64, OP_XOR32, OP_XNOR64, OP_XNOR32,
            OP_MOV64, OP_MOV32, OP_ZXT8, OP_ZXT16, OP_SXT8, OP_SXT16, OP_SXT32};
    for (k = 0; k < 15; k++)
      for (i = 0; i < LM_RANDOM; i++)
        issue(ops[k], COND_ALWAYS, 1'b1, random_flags(), next_random(), next_random());
    idle_cycle();
  endtask

  task automatic test_conditions();
    int cc;
    int fv;
    word_t x;
    word_t y;
    test_name = "test_conditions";
    for (cc = 0; cc < 16; cc++)
      for (fv = 0; fv < 64; fv++)
      begin
        x = next_random();
        y = next_random();
        issue(OP_CSET, cond_t'(cc), 1'b1, flags_t'(fv), x, y);
        issue(OP_CMOV, cond_t'(cc), 1'b1, flags_t'(fv), x, y);
      end
    idle_cycle();
  endtask

  task automatic test_streaming();
    alu_op_t ops[24];
    word_t r;
    int i;
    test_name = "test_streaming";
    // last entry is an undefined opcode
    ops = '{OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32, OP_AND64, OP_AND32, OP_OR64, OP_OR32,
            OP_XOR64, OP_XOR32, OP_XNOR64, OP_XNOR32, OP_MOV64, OP_MOV32, OP_ZXT8, OP_ZXT16,
            OP_SXT8, OP_SXT16, OP_SXT32, OP_CMOV, OP_CSET, OP_ADD64, OP_SUB32, 8'hff};
    for (i = 0; i < STREAM_OPS; i++)
    begin
      r = next_random();
      issue(ops[int'(r % 64'd24)], r[35:32], r[40], random_flags(), next_random(),
            next_random());
    end
    idle_cycle();
    idle_cycle();
  endtask

  initial
  begin
    rst = 1'b1;
    op_valid = 1'b0;
    op = OP_MOV64;
    cond = COND_ALWAYS;
    set_flags = 1'b0;
    flags_in = '0;
    a = '0;
    b = '0;
    pend = 1'b0;
    pend_narrow = 1'b0;
    pend_res = '0;
    pend_flags = '0;
    pend_we = 1'b0;
    last_res = '0;
    rng_state = 64'd89;
    test_name = "setup";
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_arith();
    test_logic_move();
    test_conditions();
    test_streaming();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
verilog/alu_data_pkg.sv
verilog/alu_op_pkg.sv
verilog/alu_decode.sv
verilog/alu_adder.sv
verilog/alu_cond_eval.sv
verilog/alu_logic_move.sv
verilog/alu_retire.sv
verilog/alu.sv
verif/alu_asserts.sv
verif/alu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the alu testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module alu_tb -Mdir obj_dir
./obj_dir/Valu_tb 2>&1 | tee sim.log
if grep -qx "Simulation passed" sim.log
then
  echo "run.sh: pass message found in sim.log"
else
  echo "run.sh: pass message missing from sim.log"
  exit 1
fi
